// ==== verilog.f ====
common/mini16_pkg.sv
source/mini16_cen.sv
video/mini16_vtimer.sv
video/mini16_char.sv
video/mini16_linebuf.sv
video/mini16_colmix.sv
source/mini16_game.sv
verification/mini16_clkgen.sv
verification/mini16_sva.sv
verification/mini16_tb.sv

// ==== Bender.yml ====
package:
  name: mini16

sources:
  - common/mini16_pkg.sv
  - source/mini16_cen.sv
  - video/mini16_vtimer.sv
  - video/mini16_char.sv
  - video/mini16_linebuf.sv
  - video/mini16_colmix.sv
  - source/mini16_game.sv
  - target: test
    files:
      - verification/mini16_clkgen.sv
      - verification/mini16_sva.sv
      - verification/mini16_tb.sv

// ==== verification/mini16_tb.sv ====
`timescale 1ns/1ps

module mini16_tb;

import mini16_pkg::*;

// The tests span about nine frames of 51200 clk
localparam int TIMEOUT_CYCLES = 600000;

logic        clk;
logic        rst_n;
cpu_wr_t     cpu;
logic        flip;
logic        video_en;
logic        pxl2_cen;
logic        pxl_cen;
logic [4:0]  red;
logic [4:0]  green;
logic [4:0]  blue;
logic        LHBL_dly;
logic        LVBL_dly;
logic        HS;
logic        VS;

// Shadow copies of the DUT memories
logic [9:0]  map_ref [MAP_DEPTH];
logic [15:0] pat_ref [PAT_DEPTH];
logic [14:0] pal_ref [PAL_DEPTH];

int          test_errors;
int          pass_count;
int          fail_count;
int          cycle_cnt;

mini16_clkgen u_clkgen(
    .clk   ( clk   ),
    .rst_n ( rst_n )
);

mini16_game i_dut(.*);

function automatic logic [14:0] ref_pixel(input int x, input int y);
    logic [9:0]  entry;
    logic [15:0] row;
    logic [1:0]  pix;
    entry = map_ref[(y / 8) * TILE_COLS + x / 8];
    row   = pat_ref[{entry[5:0], 3'(y % 8)}];
    // Leftmost pixel in the top two bits
    pix   = row[15 - 2 * (x % 8) -: 2];
    return pal_ref[{entry[9:6], pix}];
endfunction

task automatic log_error(input string msg);
    $display("[ERROR] %0t %s", $time, msg);
    test_errors++;
endtask

task automatic finish_test(input string name);
    if (test_errors == 0) begin
        pass_count++;
        $display("%s: PASS", name);
    end else begin
        fail_count++;
        $display("%s: FAIL with %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

task automatic cpu_write(input cpu_region_e region, input int addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    cpu = '{we: 1'b1, region: region, addr: 9'(addr), data: data};
    case (region)
        REG_MAP: map_ref[addr] = data[9:0];
        REG_PAT: pat_ref[addr] = data;
        REG_PAL: pal_ref[addr] = data[14:0];
        default: ;
    endcase
endtask

task automatic cpu_idle;
    @(posedge clk);
    #1;
    cpu = '{we: 1'b0, region: REG_NONE, addr: 9'd0, data: 16'd0};
endtask

task automatic drive_controls(input logic flip_v, input logic en_v);
    @(posedge clk);
    #1;
    flip     = flip_v;
    video_en = en_v;
endtask

// Outputs move only on pxl_cen, so one negedge sample per strobe sees each value once
task automatic wait_pixel_step;
    @(negedge clk);
    while (pxl_cen !== 1'b1) begin
        @(negedge clk);
    end
endtask

task automatic wait_vblank_start;
    logic prev;
    do begin
        prev = LVBL_dly;
        wait_pixel_step();
    end while (!(prev === 1'b1 && LVBL_dly === 1'b0));
endtask

task automatic wait_frame_start;
    logic prev;
    do begin
        prev = LVBL_dly;
        wait_pixel_step();
    end while (!(prev === 1'b0 && LVBL_dly === 1'b1));
endtask

task automatic check_frame(input string name, input bit blank);
    int          x;
    int          y;
    logic [14:0] exp;
    logic [14:0] got;
    wait_frame_start();
    x = 0;
    y = 0;
    while (y < V_VISIBLE) begin
        if (LHBL_dly === 1'b1 && LVBL_dly === 1'b1) begin
            exp = blank ? 15'd0 : ref_pixel(flip ? H_VISIBLE - 1 - x : x, y);
            got = {red, green, blue};
            if (got !== exp) begin
                log_error($sformatf("%s: pixel x=%0d y=%0d expected %h got %h",
                                    name, x, y, exp, got));
            end
            x++;
            if (x == H_VISIBLE) begin
                x = 0;
                y++;
            end
        end
        if (y < V_VISIBLE) begin
            wait_pixel_step();
        end
    end
endtask

task automatic test_reset;
    int   p2_cnt;
    int   p_cnt;
    logic p2_prev;
    @(posedge rst_n);
    @(negedge clk);
    if (pxl_cen !== 1'b0 || pxl2_cen !== 1'b0) begin
        log_error("reset: pixel strobes already high");
    end
    if ({red, green, blue, LHBL_dly, LVBL_dly, HS, VS} !== '0) begin
        log_error($sformatf("reset: outputs expected 0 got %b",
                            {red, green, blue, LHBL_dly, LVBL_dly, HS, VS}));
    end
    // Strobe rates over 16 consecutive clk
    wait_pixel_step();
    p2_cnt  = 0;
    p_cnt   = 0;
    p2_prev = pxl2_cen;
    for (int i = 0; i < 16; i++) begin
        @(negedge clk);
        if (pxl2_cen === 1'b1) begin
            p2_cnt++;
        end
        if (pxl_cen === 1'b1) begin
            p_cnt++;
        end
        if (p2_prev === 1'b1 && pxl2_cen === 1'b1) begin
            log_error("strobes: pxl2_cen high for two clk in a row");
        end
        p2_prev = pxl2_cen;
    end
    if (p2_cnt != 8) begin
        log_error($sformatf("strobes: pxl2_cen pulses expected 8 got %0d", p2_cnt));
    end
    if (p_cnt != 4) begin
        log_error($sformatf("strobes: pxl_cen pulses expected 4 got %0d", p_cnt));
    end
    finish_test("test 1 reset state");
endtask

task automatic test_uniform;
    // Tile 5 in bank 3 everywhere
    for (int i = 0; i < MAP_DEPTH; i++) begin
        cpu_write(REG_MAP, i, {6'd0, 4'd3, 6'd5});
    end
    for (int r = 0; r < 8; r++) begin
        cpu_write(REG_PAT, 5 * 8 + r, 16'he4e4);
    end
    for (int i = 0; i < PAL_DEPTH; i++) begin
        cpu_write(REG_PAL, i, 16'(i) * 16'h0421 + 16'h0042);
    end
    cpu_idle();
    wait_vblank_start();
    check_frame("uniform", 1'b0);
    finish_test("test 2 uniform screen");
endtask

task automatic test_random;
    for (int i = 0; i < MAP_DEPTH; i++) begin
        cpu_write(REG_MAP, i, 16'($urandom));
    end
    for (int i = 0; i < PAT_DEPTH; i++) begin
        cpu_write(REG_PAT, i, 16'($urandom));
    end
    for (int i = 0; i < PAL_DEPTH; i++) begin
        cpu_write(REG_PAL, i, 16'($urandom));
    end
    cpu_idle();
    wait_vblank_start();
    check_frame("random frame 1", 1'b0);
    check_frame("random frame 2", 1'b0);
    finish_test("test 3 random contents");
endtask

task automatic test_flip;
    drive_controls(1'b1, 1'b1);
    wait_vblank_start();
    check_frame("flip", 1'b0);
    finish_test("test 4 flip");
endtask

task automatic test_video_en;
    drive_controls(1'b0, 1'b0);
    wait_vblank_start();
    check_frame("video off", 1'b1);
    drive_controls(1'b0, 1'b1);
    wait_vblank_start();
    check_frame("video on", 1'b0);
    finish_test("test 5 video enable");
endtask

task automatic test_sync;
    int   hs_cnt;
    int   vs_lines;
    int   vis_lines;
    int   run;
    logic hs_prev;
    logic vs_prev;
    logic lhbl_prev;
    do begin
        vs_prev = VS;
        wait_pixel_step();
    end while (!(vs_prev === 1'b0 && VS === 1'b1));
    hs_cnt    = 0;
    vs_lines  = 0;
    vis_lines = 0;
    run       = 0;
    // One frame from this VS to the next
    do begin
        vs_prev   = VS;
        hs_prev   = HS;
        lhbl_prev = LHBL_dly;
        wait_pixel_step();
        if (!hs_prev && HS) begin
            hs_cnt++;
            if (VS) begin
                vs_lines++;
            end
        end
        if (!lhbl_prev && LHBL_dly) begin
            run = 0;
            if (LVBL_dly) begin
                vis_lines++;
            end
        end
        if (LHBL_dly) begin
            run++;
        end
        if (lhbl_prev && !LHBL_dly && run != H_VISIBLE) begin
            log_error($sformatf("sync: active pixels per line expected %0d got %0d",
                                H_VISIBLE, run));
        end
    end while (!(vs_prev === 1'b0 && VS === 1'b1));
    if (hs_cnt != V_TOTAL) begin
        log_error($sformatf("sync: HS pulses expected %0d got %0d", V_TOTAL, hs_cnt));
    end
    if (vs_lines != VS_END - VS_START + 1) begin
        log_error($sformatf("sync: VS lines expected %0d got %0d",
                            VS_END - VS_START + 1, vs_lines));
    end
    if (vis_lines != V_VISIBLE) begin
        log_error($sformatf("sync: visible lines expected %0d got %0d", V_VISIBLE, vis_lines));
    end
    finish_test("test 6 sync and blanking");
endtask

task automatic check_assertions;
    if (i_dut.i_sva.fail_cnt != 0) begin
        $display("Bound assertions failed %0d times", i_dut.i_sva.fail_cnt);
        test_errors += i_dut.i_sva.fail_cnt;
    end
    finish_test("bound assertions");
endtask

initial begin
    cpu         = '{we: 1'b0, region: REG_NONE, addr: 9'd0, data: 16'd0};
    flip        = 1'b0;
    video_en    = 1'b1;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    void'($urandom(32'h212ebd9f));
    test_reset();
    test_uniform();
    test_random();
    test_flip();
    test_video_en();
    test_sync();
    check_assertions();
    $display("Summary: passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_cnt++;
    end
    $display("Timeout: run stopped after %0d clock cycles", cycle_cnt);
    $display("tests failed");
    $finish;
end

endmodule

// ==== verification/mini16_sva.sv ====
`timescale 1ns/1ps

module mini16_sva(
    input                              clk,
    input                              rst_n,
    input  [mini16_pkg::COL_W-1:0]     red,
    input  [mini16_pkg::COL_W-1:0]     green,
    input  [mini16_pkg::COL_W-1:0]     blue,
    input                              LHBL_dly,
    input                              LVBL_dly,
    input                              hstart,
    input  mini16_pkg::char_state_e    char_state,
    input                              char_we
);

import mini16_pkg::*;

int fail_cnt = 0;

// Outside the active area the mixer outputs black
rgb_blanked: assert property (@(posedge clk) disable iff (!rst_n)
    (!LHBL_dly || !LVBL_dly) |-> (red == '0 && green == '0 && blue == '0))
    else begin
        $error("rgb is not zero during blanking");
        fail_cnt++;
    end

// Line start strobe
hstart_single: assert property (@(posedge clk) disable iff (!rst_n) hstart |=> !hstart)
    else begin
        $error("hstart is longer than one clk");
        fail_cnt++;
    end

// Rendering of a line ends before the next line start
render_done: assert property (@(posedge clk) disable iff (!rst_n)
    hstart |-> (char_state == CH_IDLE && !char_we))
    else begin
        $error("character layer still busy at line start");
        fail_cnt++;
    end

endmodule

bind mini16_game mini16_sva i_sva(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .red        ( red           ),
    .green      ( green         ),
    .blue       ( blue          ),
    .LHBL_dly   ( LHBL_dly      ),
    .LVBL_dly   ( LVBL_dly      ),
    .hstart     ( vpos.hstart   ),
    .char_state ( u_char.state  ),
    .char_we    ( lbuf_wr.we    )
);

// ==== verification/mini16_clkgen.sv ====
`timescale 1ns/1ps

module mini16_clkgen(
    output logic clk,
    output logic rst_n
);

initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
end

always #2 clk = ~clk;

endmodule

// ==== source/mini16_game.sv ====
`timescale 1ns/1ps

module mini16_game(
    input                               rst_n,
    input                               clk,
    input  mini16_pkg::cpu_wr_t         cpu,
    input                               flip,
    input                               video_en,
    output                              pxl2_cen,
    output                              pxl_cen,
    output [mini16_pkg::COL_W-1:0]      red,
    output [mini16_pkg::COL_W-1:0]      green,
    output [mini16_pkg::COL_W-1:0]      blue,
    output                              LHBL_dly,
    output                              LVBL_dly,
    output                              HS,
    output                              VS
);

import mini16_pkg::*;

// Video timing
vpos_t             vpos;

// Line buffer paths
lbuf_wr_t          lbuf_wr;
logic [CIDX_W-1:0] rd_cidx;
rgb_t              rgb;

assign red   = rgb.red;
assign green = rgb.green;
assign blue  = rgb.blue;

mini16_cen u_cen(
    .rst_n      ( rst_n     ),
    .clk        ( clk       ),
    .pxl2_cen   ( pxl2_cen  ),
    .pxl_cen    ( pxl_cen   )
);

mini16_vtimer u_vtimer(
    .rst_n      ( rst_n     ),
    .clk        ( clk       ),
    .pxl_cen    ( pxl_cen   ),
    .vpos       ( vpos      ),
    .HS         ( HS        ),
    .VS         ( VS        )
);

mini16_char u_char(
    .rst_n      ( rst_n     ),
    .clk        ( clk       ),
    .flip       ( flip      ),
    .cpu        ( cpu       ),
    .vpos       ( vpos      ),
    .lbuf_wr    ( lbuf_wr   )
);

mini16_linebuf u_linebuf(
    .rst_n      ( rst_n     ),
    .clk        ( clk       ),
    .vpos       ( vpos      ),
    .lbuf_wr    ( lbuf_wr   ),
    .rd_cidx    ( rd_cidx   )
);

mini16_colmix u_colmix(
    .rst_n      ( rst_n     ),
    .clk        ( clk       ),
    .pxl_cen    ( pxl_cen   ),
    .video_en   ( video_en  ),
    .cpu        ( cpu       ),
    .vpos       ( vpos      ),
    .rd_cidx    ( rd_cidx   ),
    .rgb        ( rgb       ),
    .LHBL_dly   ( LHBL_dly  ),
    .LVBL_dly   ( LVBL_dly  )
);

endmodule

// ==== video/mini16_colmix.sv ====
`timescale 1ns/1ps

module mini16_colmix(
    input                                 rst_n,
    input                                 clk,
    input                                 pxl_cen,
    input                                 video_en,
    input  mini16_pkg::cpu_wr_t           cpu,
    input  mini16_pkg::vpos_t             vpos,
    input  [mini16_pkg::CIDX_W-1:0]       rd_cidx,
    output mini16_pkg::rgb_t              rgb,
    output logic                          LHBL_dly,
    output logic                          LVBL_dly
);

import mini16_pkg::*;

rgb_t pal_mem [PAL_DEPTH];
rgb_t pal_q;
logic lhbl_d1;
logic lvbl_d1;
logic show;

// Palette RAM, first pixel step is the lookup
always_ff @(posedge clk) begin
    if (cpu.we && cpu.region == REG_PAL) begin
        pal_mem[cpu.addr[5:0]] <= rgb_t'(cpu.data[14:0]);
    end
    if (pxl_cen) begin
        pal_q <= pal_mem[rd_cidx];
    end
end

assign show = lhbl_d1 && lvbl_d1 && video_en;

// Second pixel step drives the output, blanking follows the same two steps
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        lhbl_d1  <= 1'b0;
        lvbl_d1  <= 1'b0;
        LHBL_dly <= 1'b0;
        LVBL_dly <= 1'b0;
        rgb      <= '0;
    end else if (pxl_cen) begin
        lhbl_d1  <= vpos.lhbl;
        lvbl_d1  <= vpos.lvbl;
        LHBL_dly <= lhbl_d1;
        LVBL_dly <= lvbl_d1;
        rgb      <= show ? pal_q : '0;
    end
end

endmodule

// ==== video/mini16_linebuf.sv ====
`timescale 1ns/1ps

module mini16_linebuf(
    input                                     rst_n,
    input                                     clk,
    input  mini16_pkg::vpos_t                 vpos,
    input  mini16_pkg::lbuf_wr_t              lbuf_wr,
    output logic [mini16_pkg::CIDX_W-1:0]     rd_cidx
);

import mini16_pkg::*;

// Both banks in one array, bank select is the top address bit
logic [CIDX_W-1:0] mem [2*H_VISIBLE];
logic              sel;

// Display bank is sel, the renderer fills the other one
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        sel <= 1'b0;
    end else if (vpos.hstart) begin
        sel <= ~sel;
    end
end

always_ff @(posedge clk) begin
    if (lbuf_wr.we) begin
        mem[{~sel, lbuf_wr.addr}] <= lbuf_wr.cidx;
    end
end

// hdump only moves on pxl_cen, so this is settled well before the next strobe
// Blanking positions 128 to 159 read back garbage that the mixer blanks
always_ff @(posedge clk) begin
    rd_cidx <= mem[{sel, vpos.hdump[6:0]}];
end

endmodule

// ==== video/mini16_char.sv ====
`timescale 1ns/1ps

module mini16_char(
    input                        rst_n,
    input                        clk,
    input                        flip,
    input  mini16_pkg::cpu_wr_t  cpu,
    input  mini16_pkg::vpos_t    vpos,
    output mini16_pkg::lbuf_wr_t lbuf_wr
);

import mini16_pkg::*;

// Map entry: colour bank in 9:6, tile code in 5:0
logic [9:0]  map_mem [MAP_DEPTH];
logic [15:0] pat_mem [PAT_DEPTH];

logic [9:0]  map_q;
logic [15:0] pat_q;
logic [6:0]  map_raddr;
logic [8:0]  pat_raddr;

char_state_e state;
logic [3:0]  col;
logic [2:0]  px;
logic [5:0]  line;
logic [6:0]  xpos;
logic [1:0]  pix;

// Map RAM, CPU write port and render read port
always_ff @(posedge clk) begin
    if (cpu.we && cpu.region == REG_MAP) begin
        map_mem[cpu.addr[6:0]] <= cpu.data[9:0];
    end
    map_q <= map_mem[map_raddr];
end

// Pattern RAM
always_ff @(posedge clk) begin
    if (cpu.we && cpu.region == REG_PAT) begin
        pat_mem[cpu.addr] <= cpu.data;
    end
    pat_q <= pat_mem[pat_raddr];
end

// Rows wrap every 8 tiles, so lines 64 to 79 reuse the top of the map
assign map_raddr = {line[5:3], col};
assign pat_raddr = {map_q[5:0], line[2:0]};

// Per tile: one clk map read, one clk pattern read, eight clk of pixels
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= CH_IDLE;
        col   <= 4'd0;
        px    <= 3'd0;
        line  <= 6'd0;
    end else begin
        case (state)
            CH_IDLE: begin
                if (vpos.hstart) begin
                    line  <= vpos.vrender[5:0];
                    col   <= 4'd0;
                    state <= CH_MAP;
                end
            end
            CH_MAP: begin
                state <= CH_PAT;
            end
            CH_PAT: begin
                px    <= 3'd0;
                state <= CH_DRAW;
            end
            CH_DRAW: begin
                px <= px + 3'd1;
                if (px == 3'd7) begin
                    if (col == 4'(TILE_COLS - 1)) begin
                        state <= CH_IDLE;
                    end else begin
                        col   <= col + 4'd1;
                        state <= CH_MAP;
                    end
                end
            end
            default: state <= CH_IDLE;
        endcase
    end
end

assign xpos = {col, px};

// Leftmost pixel sits in the top two bits of the word
assign pix = pat_q[{~px, 1'b1} -: 2];

always_comb begin
    lbuf_wr.we   = state == CH_DRAW;
    lbuf_wr.addr = flip ? 7'(H_VISIBLE - 1) - xpos : xpos;
    lbuf_wr.cidx = {map_q[9:6], pix};
end

endmodule

// ==== video/mini16_vtimer.sv ====
`timescale 1ns/1ps

module mini16_vtimer(
    input                     rst_n,
    input                     clk,
    input                     pxl_cen,
    output mini16_pkg::vpos_t vpos,
    output logic              HS,
    output logic              VS
);

import mini16_pkg::*;

logic [7:0] hdump;
logic [6:0] vdump;
logic [6:0] vrender;
logic       hstart;
logic       h_last;
logic       v_last;

assign h_last = hdump == 8'(H_TOTAL - 1);
assign v_last = vdump == 7'(V_TOTAL - 1);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        hdump  <= 8'd0;
        vdump  <= 7'd0;
        hstart <= 1'b0;
    end else begin
        // High in the clk right after hdump becomes 0
        hstart <= pxl_cen && h_last;
        if (pxl_cen) begin
            if (h_last) begin
                hdump <= 8'd0;
                vdump <= v_last ? 7'd0 : vdump + 7'd1;
            end else begin
                hdump <= hdump + 8'd1;
            end
        end
    end
end

// Line being drawn by the character layer, one ahead of the display
assign vrender = v_last ? 7'd0 : vdump + 7'd1;

assign HS = (hdump >= 8'(HS_START)) && (hdump <= 8'(HS_END));
assign VS = (vdump >= 7'(VS_START)) && (vdump <= 7'(VS_END));

always_comb begin
    vpos.hdump   = hdump;
    vpos.vdump   = vdump;
    vpos.vrender = vrender;
    vpos.lhbl    = hdump < 8'(H_VISIBLE);
    vpos.lvbl    = vdump < 7'(V_VISIBLE);
    vpos.hstart  = hstart;
end

endmodule

// ==== source/mini16_cen.sv ====
`timescale 1ns/1ps

module mini16_cen(
    input        rst_n,
    input        clk,
    output logic pxl2_cen,
    output logic pxl_cen
);

logic [1:0] cnt;

// Free-running divider, strobes are registered so they are clean one-clk pulses
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cnt      <= 2'd0;
        pxl2_cen <= 1'b0;
        pxl_cen  <= 1'b0;
    end else begin
        cnt      <= cnt + 2'd1;
        // Every 2nd clk
        pxl2_cen <= cnt[0];
        // Every 4th clk
        pxl_cen  <= &cnt;
    end
end

endmodule

// ==== common/mini16_pkg.sv ====
package mini16_pkg;

    // Screen geometry in pixels and lines
    localparam int H_VISIBLE = 128;
    localparam int H_TOTAL   = 160;
    localparam int V_VISIBLE = 64;
    localparam int V_TOTAL   = 80;

    // Sync windows, first and last position inclusive
    localparam int HS_START  = 136;
    localparam int HS_END    = 143;
    localparam int VS_START  = 68;
    localparam int VS_END    = 69;

    // Memory map
    localparam int TILE_COLS = 16;
    localparam int MAP_DEPTH = 128;
    localparam int PAT_DEPTH = 512;
    localparam int PAL_DEPTH = 64;

    localparam int COL_W     = 5;
    localparam int CIDX_W    = 6;

    typedef enum logic [1:0] {
        REG_MAP,
        REG_PAT,
        REG_PAL,
        REG_NONE
    } cpu_region_e;

    typedef struct packed {
        logic        we;
        cpu_region_e region;
        logic [8:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

    typedef struct packed {
        logic [7:0] hdump;
        logic [6:0] vdump;
        logic [6:0] vrender;
        logic       lhbl;
        logic       lvbl;
        logic       hstart;
    } vpos_t;

    typedef struct packed {
        logic              we;
        logic [6:0]        addr;
        logic [CIDX_W-1:0] cidx;
    } lbuf_wr_t;

    // Same bit order as a palette word
    typedef struct packed {
        logic [COL_W-1:0] red;
        logic [COL_W-1:0] green;
        logic [COL_W-1:0] blue;
    } rgb_t;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_MAP,
        CH_PAT,
        CH_DRAW
    } char_state_e;

endpackage
